// File: verilog/soc_pkg.sv
`default_nettype none

package soc_pkg;

	// internal bus
	typedef logic [15:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;

	// board io
	typedef logic [7:0] led_t;
	typedef logic [3:0] sw_t;

	// ascii host command opcodes
	typedef enum logic [7:0] {
		CMD_WRITE = 8'h57,
		CMD_READ  = 8'h52
	} cmd_opcode_e;

	// single byte replies
	localparam logic [7:0] REPLY_OK  = 8'h4B;
	localparam logic [7:0] REPLY_ERR = 8'h45;

	// led register with the switches at the next word
	localparam bus_addr_t GPIO_BASE = 16'h8000;

	// serial frame phases shared by rx and tx
	typedef enum logic [1:0] {
		UART_IDLE,
		UART_START,
		UART_DATA,
		UART_STOP
	} uart_state_e;

endpackage

`default_nettype wire

// File: verilog/uart_rx.sv
`default_nettype none

module uart_rx import soc_pkg::*; #(
	parameter int CLKS_PER_BIT = 16
) (
	input  wire logic       clk,
	input  wire logic       reset,
	input  wire logic       rxd,
	output logic            rx_valid,
	output logic [7:0]      rx_byte
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(CLKS_PER_BIT / 2 - 1);
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);

	uart_state_e      state;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0]       bit_idx;
	logic             rxd_meta;
	logic             rxd_s;

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= UART_IDLE;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
			rxd_meta <= 1'b1;
			rxd_s    <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_s    <= rxd_meta;
			rx_valid <= 1'b0;
			case (state)
				UART_IDLE: begin
					clk_cnt <= '0;
					if (!rxd_s)
						state <= UART_START;
				end
				UART_START: begin
					// line must still be low mid start bit
					if (clk_cnt == HALF_CNT) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						state   <= rxd_s ? UART_IDLE : UART_DATA;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				UART_DATA: begin
					if (clk_cnt == LAST_CNT) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= UART_STOP;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				UART_STOP: begin
					if (clk_cnt == LAST_CNT) begin
						// framing error drops the byte
						rx_valid <= rxd_s;
						state    <= UART_IDLE;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= UART_IDLE;
			endcase
		end
	end

	// lsb first
	always_ff @(posedge clk) begin
		if (state == UART_DATA && clk_cnt == LAST_CNT)
			rx_byte <= {rxd_s, rx_byte[7:1]};
	end

endmodule

`default_nettype wire

// File: verilog/host_cmd_parser.sv
`default_nettype none

module host_cmd_parser import soc_pkg::*; (
	input  wire logic       clk,
	input  wire logic       reset,
	input  wire logic       rx_valid,
	input  wire logic [7:0] rx_byte,
	output logic            bus_req,
	output logic            bus_we,
	output bus_addr_t       bus_addr,
	output bus_data_t       bus_wdata,
	input  wire logic       bus_ack,
	input  wire bus_data_t  bus_rdata,
	input  wire logic       bus_err,
	output logic            tx_req,
	output logic [7:0]      tx_byte,
	input  wire logic       tx_ack
);

	typedef enum logic [2:0] {
		ST_OPCODE,
		ST_ADDR,
		ST_DATA,
		ST_BUS,
		ST_REPLY
	} parser_state_e;

	parser_state_e state;
	logic [1:0]    byte_cnt;
	logic [1:0]    reply_left;
	logic [23:0]   reply_sh;

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= ST_OPCODE;
			byte_cnt   <= '0;
			reply_left <= '0;
			bus_req    <= 1'b0;
			tx_req     <= 1'b0;
		end else begin
			case (state)
				ST_OPCODE: begin
					byte_cnt <= '0;
					if (rx_valid) begin
						case (rx_byte)
							CMD_WRITE, CMD_READ: state <= ST_ADDR;
							default: begin
								reply_left <= '0;
								state      <= ST_REPLY;
							end
						endcase
					end
				end
				ST_ADDR: begin
					if (rx_valid) begin
						byte_cnt <= byte_cnt + 1'b1;
						if (byte_cnt == 2'd1) begin
							byte_cnt <= '0;
							state    <= bus_we ? ST_DATA : ST_BUS;
						end
					end
				end
				ST_DATA: begin
					if (rx_valid) begin
						byte_cnt <= byte_cnt + 1'b1;
						if (byte_cnt == 2'd3)
							state <= ST_BUS;
					end
				end
				ST_BUS: begin
					if (bus_req) begin
						if (bus_ack) begin
							bus_req    <= 1'b0;
							reply_left <= (bus_err || bus_we) ? 2'd0 : 2'd3;
							state      <= ST_REPLY;
						end
					end else if (!bus_ack) begin
						bus_req <= 1'b1;
					end
				end
				ST_REPLY: begin
					if (tx_req) begin
						if (tx_ack) begin
							tx_req     <= 1'b0;
							reply_left <= reply_left - 1'b1;
							if (reply_left == 2'd0)
								state <= ST_OPCODE;
						end
					end else if (!tx_ack) begin
						tx_req <= 1'b1;
					end
				end
				default: state <= ST_OPCODE;
			endcase
		end
	end

	// command fields and reply bytes
	always_ff @(posedge clk) begin
		if (state == ST_OPCODE && rx_valid) begin
			bus_we  <= (rx_byte == CMD_WRITE);
			tx_byte <= REPLY_ERR;
		end
		if (state == ST_ADDR && rx_valid)
			bus_addr <= {bus_addr[7:0], rx_byte};
		if (state == ST_DATA && rx_valid)
			bus_wdata <= {bus_wdata[23:0], rx_byte};
		if (state == ST_BUS && bus_req && bus_ack) begin
			reply_sh <= bus_rdata[23:0];
			if (bus_err)
				tx_byte <= REPLY_ERR;
			else if (bus_we)
				tx_byte <= REPLY_OK;
			else
				tx_byte <= bus_rdata[31:24];
		end
		// next read byte goes out msb first
		if (state == ST_REPLY && tx_req && tx_ack) begin
			tx_byte  <= reply_sh[23:16];
			reply_sh <= {reply_sh[15:0], 8'h00};
		end
	end

endmodule

`default_nettype wire

// File: verilog/addr_decoder.sv
`default_nettype none

module addr_decoder import soc_pkg::*; #(
	parameter int MEM_ADDR_BITS = 11
) (
	input  wire logic                     clk,
	input  wire logic                     reset,
	input  wire logic                     bus_req,
	input  wire logic                     bus_we,
	input  wire bus_addr_t                bus_addr,
	input  wire bus_data_t                bus_wdata,
	output logic                          bus_ack,
	output bus_data_t                     bus_rdata,
	output logic                          bus_err,
	output logic                          mem_en,
	output logic                          mem_we,
	output logic [MEM_ADDR_BITS-1:0]      mem_addr,
	output bus_data_t                     mem_wdata,
	input  wire bus_data_t                mem_rdata,
	output logic                          gpio_en,
	output logic                          gpio_we,
	output logic                          gpio_sel,
	output led_t                          gpio_wdata,
	input  wire bus_data_t                gpio_rdata
);

	logic req_q;
	logic start;
	logic is_mem;
	logic is_led;
	logic is_sw;
	logic err;
	logic pend;
	logic pend_gpio;
	logic pend_err;

	assign start  = bus_req && !req_q && !bus_ack;
	assign is_mem = (bus_addr[15:MEM_ADDR_BITS] == '0);
	assign is_led = (bus_addr == GPIO_BASE);
	assign is_sw  = (bus_addr == bus_addr_t'(GPIO_BASE + 16'd1));
	// switches are read only
	assign err    = !(is_mem || is_led || is_sw) || (is_sw && bus_we);

	assign mem_en     = start && is_mem;
	assign mem_we     = bus_we;
	assign mem_addr   = bus_addr[MEM_ADDR_BITS-1:0];
	assign mem_wdata  = bus_wdata;
	assign gpio_en    = start && (is_led || is_sw) && !err;
	assign gpio_we    = bus_we;
	assign gpio_sel   = bus_addr[0];
	assign gpio_wdata = bus_wdata[7:0];

	always_ff @(posedge clk) begin
		if (reset) begin
			req_q   <= 1'b0;
			pend    <= 1'b0;
			bus_ack <= 1'b0;
		end else begin
			req_q <= bus_req;
			pend  <= start;
			// target data lands while pend is high
			if (pend)
				bus_ack <= 1'b1;
			else if (!bus_req)
				bus_ack <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			pend_gpio <= !is_mem;
			pend_err  <= err;
		end
		if (pend) begin
			bus_err   <= pend_err;
			bus_rdata <= pend_err ? '0 : (pend_gpio ? gpio_rdata : mem_rdata);
		end
	end

endmodule

`default_nettype wire

// File: verilog/mem_bank.sv
`default_nettype none

module mem_bank import soc_pkg::*; #(
	parameter int MEM_ADDR_BITS = 11
) (
	input  wire logic                     clk,
	input  wire logic                     en,
	input  wire logic                     we,
	input  wire logic [MEM_ADDR_BITS-1:0] addr,
	input  wire bus_data_t                wdata,
	output bus_data_t                     rdata
);

	localparam int DEPTH = 1 << MEM_ADDR_BITS;

	bus_data_t mem [DEPTH];

	// single port with read before write
	always_ff @(posedge clk) begin
		if (en) begin
			if (we)
				mem[addr] <= wdata;
			rdata <= mem[addr];
		end
	end

endmodule

`default_nettype wire

// File: verilog/gpio_regs.sv
`default_nettype none

module gpio_regs import soc_pkg::*; (
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic en,
	input  wire logic we,
	input  wire logic sel,
	input  wire led_t wdata,
	output bus_data_t rdata,
	input  wire sw_t  sw,
	output led_t      led
);

	sw_t sw_meta;
	sw_t sw_s;

	always_ff @(posedge clk) begin
		if (reset)
			led <= '0;
		else if (en && we && !sel)
			led <= wdata;
	end

	// switches are asynchronous to clk
	always_ff @(posedge clk) begin
		sw_meta <= sw;
		sw_s    <= sw_meta;
	end

	always_ff @(posedge clk) begin
		if (en)
			rdata <= sel ? bus_data_t'(sw_s) : bus_data_t'(led);
	end

endmodule

`default_nettype wire

// File: verilog/uart_tx.sv
`default_nettype none

module uart_tx import soc_pkg::*; #(
	parameter int CLKS_PER_BIT = 16
) (
	input  wire logic       clk,
	input  wire logic       reset,
	input  wire logic       tx_req,
	input  wire logic [7:0] tx_byte,
	output logic            tx_ack,
	output logic            txd
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);

	uart_state_e      state;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shreg;
	logic             launch;
	logic             bit_end;

	assign launch  = (state == UART_IDLE) && tx_req && !tx_ack;
	assign bit_end = (clk_cnt == LAST_CNT);

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= UART_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			tx_ack  <= 1'b0;
			txd     <= 1'b1;
		end else begin
			clk_cnt <= (state == UART_IDLE || bit_end) ? '0 : clk_cnt + 1'b1;
			case (state)
				UART_IDLE: begin
					if (tx_ack && !tx_req)
						tx_ack <= 1'b0;
					if (launch) begin
						txd   <= 1'b0;
						state <= UART_START;
					end
				end
				UART_START: begin
					if (bit_end) begin
						txd     <= shreg[0];
						bit_idx <= '0;
						state   <= UART_DATA;
					end
				end
				UART_DATA: begin
					if (bit_end) begin
						bit_idx <= bit_idx + 1'b1;
						txd     <= (bit_idx == 3'd7) ? 1'b1 : shreg[1];
						if (bit_idx == 3'd7)
							state <= UART_STOP;
					end
				end
				UART_STOP: begin
					// ack held until the requester lets go
					if (bit_end) begin
						tx_ack <= 1'b1;
						state  <= UART_IDLE;
					end
				end
				default: state <= UART_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (launch)
			shreg <= tx_byte;
		else if (state == UART_DATA && bit_end)
			shreg <= {1'b0, shreg[7:1]};
	end

endmodule

`default_nettype wire

// File: verilog/soc_top.sv
`default_nettype none

module soc_top import soc_pkg::*; #(
	parameter int CLKS_PER_BIT  = 16,
	parameter int MEM_ADDR_BITS = 11
) (
	input  wire logic clk,
	input  wire logic reset,
	input  wire sw_t  sw,
	input  wire logic uart_rx,
	output logic      uart_tx,
	output led_t      led
);

	logic                     rx_valid;
	logic [7:0]               rx_byte;
	logic                     bus_req;
	logic                     bus_we;
	bus_addr_t                bus_addr;
	bus_data_t                bus_wdata;
	logic                     bus_ack;
	bus_data_t                bus_rdata;
	logic                     bus_err;
	logic                     mem_en;
	logic                     mem_we;
	logic [MEM_ADDR_BITS-1:0] mem_addr;
	bus_data_t                mem_wdata;
	bus_data_t                mem_rdata;
	logic                     gpio_en;
	logic                     gpio_we;
	logic                     gpio_sel;
	led_t                     gpio_wdata;
	bus_data_t                gpio_rdata;
	logic                     tx_req;
	logic [7:0]               tx_byte;
	logic                     tx_ack;

	uart_rx #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) rx_i (
		.clk      (clk),
		.reset    (reset),
		.rxd      (uart_rx),
		.rx_valid (rx_valid),
		.rx_byte  (rx_byte)
	);

	host_cmd_parser parser_i (
		.clk       (clk),
		.reset     (reset),
		.rx_valid  (rx_valid),
		.rx_byte   (rx_byte),
		.bus_req   (bus_req),
		.bus_we    (bus_we),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.bus_ack   (bus_ack),
		.bus_rdata (bus_rdata),
		.bus_err   (bus_err),
		.tx_req    (tx_req),
		.tx_byte   (tx_byte),
		.tx_ack    (tx_ack)
	);

	addr_decoder #(
		.MEM_ADDR_BITS(MEM_ADDR_BITS)
	) decoder_i (
		.clk        (clk),
		.reset      (reset),
		.bus_req    (bus_req),
		.bus_we     (bus_we),
		.bus_addr   (bus_addr),
		.bus_wdata  (bus_wdata),
		.bus_ack    (bus_ack),
		.bus_rdata  (bus_rdata),
		.bus_err    (bus_err),
		.mem_en     (mem_en),
		.mem_we     (mem_we),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_rdata  (mem_rdata),
		.gpio_en    (gpio_en),
		.gpio_we    (gpio_we),
		.gpio_sel   (gpio_sel),
		.gpio_wdata (gpio_wdata),
		.gpio_rdata (gpio_rdata)
	);

	mem_bank #(
		.MEM_ADDR_BITS(MEM_ADDR_BITS)
	) mem_i (
		.clk   (clk),
		.en    (mem_en),
		.we    (mem_we),
		.addr  (mem_addr),
		.wdata (mem_wdata),
		.rdata (mem_rdata)
	);

	gpio_regs gpio_i (
		.clk   (clk),
		.reset (reset),
		.en    (gpio_en),
		.we    (gpio_we),
		.sel   (gpio_sel),
		.wdata (gpio_wdata),
		.rdata (gpio_rdata),
		.sw    (sw),
		.led   (led)
	);

	uart_tx #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) tx_i (
		.clk     (clk),
		.reset   (reset),
		.tx_req  (tx_req),
		.tx_byte (tx_byte),
		.tx_ack  (tx_ack),
		.txd     (uart_tx)
	);

endmodule

`default_nettype wire

// File: sim/soc_tb.sv
`default_nettype none

module soc_tb;

	localparam int CLKS_PER_BIT  = 16;
	localparam int MEM_ADDR_BITS = 11;
	localparam int CLK_PERIOD    = 8;
	localparam int HALF_BIT      = CLKS_PER_BIT / 2;
	localparam int RECV_LIMIT    = 20 * CLKS_PER_BIT;
	// frames sent and received over all tests
	localparam int TOTAL_FRAMES  = 186;
	localparam int WATCHDOG_TIME = TOTAL_FRAMES * 10 * CLKS_PER_BIT * CLK_PERIOD * 2;

	localparam logic [7:0]  OP_WRITE = 8'h57;
	localparam logic [7:0]  OP_READ  = 8'h52;
	localparam logic [7:0]  ACK_OK   = 8'h4B;
	localparam logic [7:0]  ACK_ERR  = 8'h45;
	localparam logic [15:0] LED_ADDR = 16'h8000;
	localparam logic [15:0] SW_ADDR  = 16'h8001;

	logic        clk;
	logic        reset;
	logic [3:0]  sw;
	logic        host_txd;
	logic        host_rxd;
	logic [7:0]  led;

	int          error_count;
	logic [31:0] lcg_state;
	logic [31:0] mem5_word;
	logic [7:0]  cmd_q[$];
	logic [7:0]  reply_q[$];

	soc_top #(
		.CLKS_PER_BIT  (CLKS_PER_BIT),
		.MEM_ADDR_BITS (MEM_ADDR_BITS)
	) dut_i (
		.clk     (clk),
		.reset   (reset),
		.sw      (sw),
		.uart_rx (host_txd),
		.uart_tx (host_rxd),
		.led     (led)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("watchdog expired before the tests completed, %0d error(s) so far",
			error_count);
		$display("*** TEST FAILED ***");
		$finish;
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_equal(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s = %h, expected %h",
				$time, name, actual, expected);
			error_count++;
		end
	endtask

	task automatic uart_send_byte(input logic [7:0] data);
		int i;
		@(negedge clk);
		host_txd = 1'b0;
		repeat (CLKS_PER_BIT) @(negedge clk);
		for (i = 0; i < 8; i++) begin
			host_txd = data[i];
			repeat (CLKS_PER_BIT) @(negedge clk);
		end
		host_txd = 1'b1;
		repeat (CLKS_PER_BIT) @(negedge clk);
	endtask

	task automatic uart_recv_byte(output logic [7:0] data, output logic ok);
		int waited;
		int i;
		ok = 1'b0;
		data = 8'h00;
		waited = 0;
		while (host_rxd !== 1'b0 && waited < RECV_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (host_rxd !== 1'b0) begin
			$display("ERROR at %0t: no start bit on uart_tx within %0d cycles",
				$time, RECV_LIMIT);
			error_count++;
			return;
		end
		repeat (HALF_BIT) @(negedge clk);
		if (host_rxd !== 1'b0) begin
			$display("ERROR at %0t: start bit on uart_tx ended early", $time);
			error_count++;
			return;
		end
		for (i = 0; i < 8; i++) begin
			repeat (CLKS_PER_BIT) @(negedge clk);
			data[i] = host_rxd;
		end
		repeat (CLKS_PER_BIT) @(negedge clk);
		if (host_rxd !== 1'b1) begin
			$display("ERROR at %0t: stop bit on uart_tx is not high", $time);
			error_count++;
			return;
		end
		ok = 1'b1;
	endtask

	task automatic receive_reply(input int count);
		logic [7:0] b;
		logic       ok;
		int         k;
		for (k = 0; k < count; k++) begin
			uart_recv_byte(b, ok);
			if (!ok)
				break;
			reply_q.push_back(b);
		end
	endtask

	// reply may start before the last stop bit is over
	task automatic run_command(input int reply_len);
		int n;
		int i;
		n = cmd_q.size();
		reply_q.delete();
		for (i = 0; i < n - 1; i++)
			uart_send_byte(cmd_q[i]);
		fork
			uart_send_byte(cmd_q[n-1]);
			receive_reply(reply_len);
		join
		cmd_q.delete();
	endtask

	task automatic write_expect(input logic [15:0] addr, input logic [31:0] data,
			input logic [7:0] reply);
		cmd_q.delete();
		cmd_q.push_back(OP_WRITE);
		cmd_q.push_back(addr[15:8]);
		cmd_q.push_back(addr[7:0]);
		cmd_q.push_back(data[31:24]);
		cmd_q.push_back(data[23:16]);
		cmd_q.push_back(data[15:8]);
		cmd_q.push_back(data[7:0]);
		run_command(1);
		check_equal("write reply length", 32'(reply_q.size()), 32'd1);
		if (reply_q.size() == 1)
			check_equal($sformatf("write reply for %h", addr),
				32'(reply_q[0]), 32'(reply));
	endtask

	task automatic read_expect(input logic [15:0] addr, input logic [31:0] expected);
		cmd_q.delete();
		cmd_q.push_back(OP_READ);
		cmd_q.push_back(addr[15:8]);
		cmd_q.push_back(addr[7:0]);
		run_command(4);
		check_equal("read reply length", 32'(reply_q.size()), 32'd4);
		if (reply_q.size() == 4)
			check_equal($sformatf("read data at %h", addr),
				{reply_q[0], reply_q[1], reply_q[2], reply_q[3]}, expected);
	endtask

	task automatic read_expect_error(input logic [15:0] addr);
		cmd_q.delete();
		cmd_q.push_back(OP_READ);
		cmd_q.push_back(addr[15:8]);
		cmd_q.push_back(addr[7:0]);
		run_command(1);
		check_equal("read error length", 32'(reply_q.size()), 32'd1);
		if (reply_q.size() == 1)
			check_equal($sformatf("read reply for %h", addr),
				32'(reply_q[0]), 32'(ACK_ERR));
	endtask

	task automatic test_mem_write_read();
		mem5_word = 32'h9E37_79B9;
		write_expect(16'd5, mem5_word, ACK_OK);
		read_expect(16'd5, mem5_word);
	endtask

	task automatic test_led();
		write_expect(LED_ADDR, 32'h1234_56A5, ACK_OK);
		check_equal("led", 32'(led), 32'h0000_00A5);
		read_expect(LED_ADDR, 32'h0000_00A5);
	endtask

	task automatic test_switch();
		sw = 4'b1011;
		repeat (4) @(negedge clk);
		read_expect(SW_ADDR, 32'h0000_000B);
		write_expect(SW_ADDR, 32'h0000_0005, ACK_ERR);
	endtask

	task automatic test_unmapped();
		read_expect_error(16'h4000);
		write_expect(16'h4000, 32'h0BAD_F00D, ACK_ERR);
	endtask

	task automatic test_bad_opcode();
		cmd_q.delete();
		cmd_q.push_back(8'h41);
		run_command(1);
		check_equal("bad opcode reply length", 32'(reply_q.size()), 32'd1);
		if (reply_q.size() == 1)
			check_equal("bad opcode reply", 32'(reply_q[0]), 32'(ACK_ERR));
		read_expect(16'd5, mem5_word);
	endtask

	task automatic test_random_words();
		logic [15:0] addrs [8];
		logic [31:0] words [8];
		int          i;
		addrs = '{16'd0, 16'd17, 16'd300, 16'd555,
			16'd1024, 16'd1500, 16'd2000, 16'd2047};
		for (i = 0; i < 8; i++) begin
			words[i] = next_random();
			write_expect(addrs[i], words[i], ACK_OK);
		end
		for (i = 0; i < 8; i++)
			read_expect(addrs[i], words[i]);
	endtask

	initial begin
		host_txd = 1'b1;
		sw = 4'b0000;
		reset = 1'b1;
		error_count = 0;
		lcg_state = 32'h41560928;
		repeat (10) @(negedge clk);
		reset = 1'b0;
		repeat (4) @(negedge clk);

		// leds cleared and serial line idle out of reset
		check_equal("led after reset", 32'(led), 32'h0000_0000);
		check_equal("uart_tx after reset", 32'(host_rxd), 32'h0000_0001);

		test_mem_write_read();
		test_led();
		test_switch();
		test_unmapped();
		test_bad_opcode();
		test_random_words();

		$display("tests done with %0d error(s)", error_count);
		if (error_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
verilog/soc_pkg.sv
verilog/uart_rx.sv
verilog/host_cmd_parser.sv
verilog/addr_decoder.sv
verilog/mem_bank.sv
verilog/gpio_regs.sv
verilog/uart_tx.sv
verilog/soc_top.sv
sim/soc_tb.sv

// File: run.sh
#!/bin/sh
# build and run the soc testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module soc_tb -f flist.f -o soc_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/soc_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** TEST PASSED ***'; then
	exit 0
fi
exit 1
